//--- logic/exec_alu.sv
`timescale 1ns/10ps

module exec_alu
(
    input  wire                                   i_clk,
    input  wire                                   i_reset,
    input  wire                                   i_flush,
    input  wire                                   i_valid,
    input  rv_exec_pkg::exec_req_t                i_bundle,
    output logic                                  o_valid,
    output rv_exec_pkg::exec_res_t                o_res,
    output logic                                  o_eq,
    output logic                                  o_lts,
    output logic                                  o_ltu,
    output rv_exec_pkg::branch_ctl_t              o_ctl,
    output logic [rv_exec_pkg::XLEN-1:0]          o_reg_data2
);

    rv_exec_pkg::exec_req_t          stage;
    logic                            valid_q;
    rv_exec_pkg::int_ctl_t           ictl;
    rv_exec_pkg::md_ctl_t            mctl;
    logic [rv_exec_pkg::XLEN-1:0]    op1;
    logic [rv_exec_pkg::XLEN-1:0]    op2;
    logic [rv_exec_pkg::XLEN-1:0]    op_b;
    logic [rv_exec_pkg::XLEN:0]      sum;
    logic                            overflow;
    logic [rv_exec_pkg::XLEN-1:0]    shl;
    logic [rv_exec_pkg::XLEN-1:0]    sra;
    logic [rv_exec_pkg::XLEN-1:0]    shr;
    logic [rv_exec_pkg::XLEN-1:0]    int_res;
    logic                            neg1;
    logic                            neg2;
    logic [rv_exec_pkg::XLEN-1:0]    mag1;
    logic [rv_exec_pkg::XLEN-1:0]    mag2;
    logic [2*rv_exec_pkg::XLEN-1:0]  prod;
    logic [2*rv_exec_pkg::XLEN-1:0]  prod_s;
    logic                            div_zero;
    logic                            q_neg;
    logic [rv_exec_pkg::XLEN-1:0]    quot;
    logic [rv_exec_pkg::XLEN-1:0]    rmd;
    logic [rv_exec_pkg::XLEN-1:0]    m_res;
    logic [rv_exec_pkg::XLEN-1:0]    result;

    // Operands and controls for stage 2
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            stage <= i_bundle;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid;
        end
    end

    assign ictl = stage.alu_sub.int_ctl;
    assign mctl = stage.alu_sub.md_ctl;
    assign op1  = stage.op1;
    assign op2  = stage.op2;

    // The compares need neg set so that the adder subtracts
    assign op_b     = ictl.neg ? ~op2 : op2;
    assign sum      = {1'b0, op1} + {1'b0, op_b} + {{rv_exec_pkg::XLEN{1'b0}}, ictl.neg};
    assign overflow = (op1[rv_exec_pkg::XLEN-1] ^ op2[rv_exec_pkg::XLEN-1]) &
                      (op1[rv_exec_pkg::XLEN-1] ^ sum[rv_exec_pkg::XLEN-1]);

    assign o_eq  = ictl.inv ^ (op1 == op2);
    assign o_lts = ictl.inv ^ (sum[rv_exec_pkg::XLEN-1] ^ overflow);
    assign o_ltu = ictl.inv ^ !sum[rv_exec_pkg::XLEN];

    assign shl = op1 << op2[4:0];
    assign sra = $signed(op1) >>> op2[4:0];
    assign shr = ictl.neg ? sra : (op1 >> op2[4:0]);

    always_comb
    begin
        case (ictl.sel)
            3'b000:  int_res = sum[rv_exec_pkg::XLEN-1:0];
            3'b001:  int_res = shl;
            3'b010:  int_res = {{(rv_exec_pkg::XLEN-1){1'b0}}, o_lts};
            3'b011:  int_res = {{(rv_exec_pkg::XLEN-1){1'b0}}, o_ltu};
            3'b100:  int_res = op1 ^ op2;
            3'b101:  int_res = shr;
            3'b110:  int_res = op1 | op2;
            default: int_res = op1 & op2;
        endcase
    end

    // Work on magnitudes and apply the sign afterwards
    assign neg1 = mctl.sgn1 & op1[rv_exec_pkg::XLEN-1];
    assign neg2 = mctl.sgn2 & op2[rv_exec_pkg::XLEN-1];
    assign mag1 = neg1 ? (~op1 + 1'b1) : op1;
    assign mag2 = neg2 ? (~op2 + 1'b1) : op2;

    assign prod   = {{rv_exec_pkg::XLEN{1'b0}}, mag1} * {{rv_exec_pkg::XLEN{1'b0}}, mag2};
    assign prod_s = (neg1 ^ neg2) ? (~prod + 1'b1) : prod;

    // A zero divisor gives all ones and the dividend back
    assign div_zero = (mag2 == '0);
    assign quot     = div_zero ? '1 : (mag1 / mag2);
    assign rmd      = div_zero ? mag1 : (mag1 % mag2);
    assign q_neg    = (neg1 ^ neg2) & !div_zero;

    always_comb
    begin
        case (mctl.sel)
            3'b000:          m_res = prod_s[rv_exec_pkg::XLEN-1:0];
            3'b001, 3'b010,
            3'b011:          m_res = prod_s[2*rv_exec_pkg::XLEN-1:rv_exec_pkg::XLEN];
            3'b100, 3'b101:  m_res = q_neg ? (~quot + 1'b1) : quot;
            default:         m_res = neg1 ? (~rmd + 1'b1) : rmd;    // Sign follows the dividend
        endcase
    end

    always_comb
    begin
        if (stage.res_src.pc_next)
        begin
            result = stage.pc_next;
        end
        else if (rv_exec_pkg::EXT_ZICSR && stage.csr_read)
        begin
            result = stage.csr_data;
        end
        else if (ictl.muldiv)
        begin
            result = m_res;
        end
        else
        begin
            result = int_res;
        end
    end

    always_comb
    begin
        o_res           = '0;                   // Store lanes are filled in at the top
        o_res.result    = result;
        o_res.add       = sum[rv_exec_pkg::XLEN-1:0];
        o_res.rd        = stage.rd;
        o_res.reg_write = stage.reg_write & valid_q;
        o_res.store     = stage.store & valid_q;
        o_res.funct3    = stage.funct3;
        o_res.res_src   = stage.res_src;
        o_res.pc        = stage.pc;
        o_res.to_trap   = stage.to_trap & valid_q;
    end

    assign o_ctl.jal_jalr    = stage.jal_jalr;
    assign o_ctl.branch      = stage.branch;
    assign o_ctl.branch_pred = stage.branch_pred;
    assign o_ctl.pc_target   = stage.pc_target;
    assign o_ctl.pc_next     = stage.pc_next;
    assign o_ctl.funct3      = stage.funct3;

    assign o_reg_data2 = stage.reg_data2;
    assign o_valid     = valid_q;

endmodule

//--- logic/exec_branch.sv
`timescale 1ns/10ps

module exec_branch
(
    input  rv_exec_pkg::branch_ctl_t                i_ctl,
    input  wire                                     i_eq,
    input  wire                                     i_lts,
    input  wire                                     i_ltu,
    input  wire [rv_exec_pkg::IADDR_BITS-1:0]       i_fetch_pc,
    output rv_exec_pkg::redirect_t                  o_redirect
);

    logic cond;
    logic taken;
    logic pred_ok;

    // Bit 0 of funct3 is already folded into the inv control
    always_comb
    begin
        case (i_ctl.funct3[2:1])
            2'b00:   cond = i_eq;
            2'b10:   cond = i_lts;
            default: cond = i_ltu;
        endcase
    end

    assign taken = i_ctl.jal_jalr | (i_ctl.branch & cond);

    // Fetch already followed the predicted target
    assign pred_ok = rv_exec_pkg::BRANCH_PREDICTION & i_ctl.branch_pred &
                     (i_ctl.pc_target == i_fetch_pc);

    assign o_redirect.pc_select = taken ^ pred_ok;
    assign o_redirect.target    = pred_ok ? i_ctl.pc_next : i_ctl.pc_target;

endmodule

//--- logic/exec_issue.sv
`timescale 1ns/10ps

module exec_issue
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_flush,
    input  wire                     i_req,
    input  rv_exec_pkg::exec_req_t  i_issue,
    output logic                    o_ack,
    output logic                    o_valid,
    output rv_exec_pkg::exec_req_t  o_bundle
);

    logic                   ack_q;
    logic                   valid_q;
    logic                   take;
    rv_exec_pkg::exec_req_t bundle_q;

    assign take = i_req && !ack_q;              // New request while idle

    // Ack drops one edge after req is seen low
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            ack_q <= 1'b0;
        end
        else if (take)
        begin
            ack_q <= 1'b1;
        end
        else if (!i_req)
        begin
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= take;                    // One strobe per handshake
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (take)
        begin
            bundle_q <= i_issue;
        end
    end

    assign o_ack    = ack_q;
    assign o_valid  = valid_q;
    assign o_bundle = bundle_q;

endmodule

//--- logic/exec_store_fmt.sv
`timescale 1ns/10ps

module exec_store_fmt
(
    input  wire [2:0]                       i_funct3,
    input  wire [1:0]                       i_addr_lo,
    input  wire [rv_exec_pkg::XLEN-1:0]     i_reg_data2,
    output logic [rv_exec_pkg::XLEN-1:0]    o_wdata,
    output logic [3:0]                      o_wsel
);

    always_comb
    begin
        case (i_funct3[1:0])
            2'b00:   o_wdata = {4{i_reg_data2[7:0]}};
            2'b01:   o_wdata = {2{i_reg_data2[15:0]}};
            default: o_wdata = i_reg_data2;
        endcase
    end

    always_comb
    begin
        case (i_funct3[1:0])
            2'b00:
            begin
                o_wsel = 4'b0001 << i_addr_lo;      // One lane per byte address
            end
            2'b01:
            begin
                o_wsel = i_addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_wsel = 4'b1111;
            end
        endcase
    end

endmodule

//--- logic/exec_top.sv
`timescale 1ns/10ps

module exec_top
(
    input  wire                                 i_clk,
    input  wire                                 i_reset,
    input  wire                                 i_flush,
    input  wire                                 i_req,
    input  rv_exec_pkg::exec_req_t              i_issue,
    input  wire [rv_exec_pkg::IADDR_BITS-1:0]   i_fetch_pc,
    output logic                                o_ack,
    output logic                                o_res_valid,
    output rv_exec_pkg::exec_res_t              o_result,
    output rv_exec_pkg::redirect_t              o_redirect
);

    logic                           iss_valid;
    rv_exec_pkg::exec_req_t         iss_bundle;
    logic                           alu_valid;
    rv_exec_pkg::exec_res_t         alu_res;
    logic                           eq;
    logic                           lts;
    logic                           ltu;
    rv_exec_pkg::branch_ctl_t       br_ctl;
    logic [rv_exec_pkg::XLEN-1:0]   reg_data2;
    rv_exec_pkg::redirect_t         redirect;
    logic [rv_exec_pkg::XLEN-1:0]   wdata;
    logic [3:0]                     wsel;

    exec_issue issue0
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_req      (i_req),
        .i_issue    (i_issue),
        .o_ack      (o_ack),
        .o_valid    (iss_valid),
        .o_bundle   (iss_bundle)
    );

    exec_alu alu0
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_flush     (i_flush),
        .i_valid     (iss_valid),
        .i_bundle    (iss_bundle),
        .o_valid     (alu_valid),
        .o_res       (alu_res),
        .o_eq        (eq),
        .o_lts       (lts),
        .o_ltu       (ltu),
        .o_ctl       (br_ctl),
        .o_reg_data2 (reg_data2)
    );

    exec_branch branch0
    (
        .i_ctl       (br_ctl),
        .i_eq        (eq),
        .i_lts       (lts),
        .i_ltu       (ltu),
        .i_fetch_pc  (i_fetch_pc),
        .o_redirect  (redirect)
    );

    exec_store_fmt store0
    (
        .i_funct3    (alu_res.funct3),
        .i_addr_lo   (alu_res.add[1:0]),
        .i_reg_data2 (reg_data2),
        .o_wdata     (wdata),
        .o_wsel      (wsel)
    );

    always_comb
    begin
        o_result       = alu_res;
        o_result.wdata = wdata;
        o_result.wsel  = wsel;
    end

    assign o_res_valid          = alu_valid;
    assign o_redirect.pc_select = redirect.pc_select & alu_valid;  // Only for a live result
    assign o_redirect.target    = redirect.target;

endmodule

//--- logic/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int   XLEN              = 32;
    localparam int   IADDR_BITS        = 32;
    localparam logic BRANCH_PREDICTION = 1'b1;
    localparam logic EXT_ZICSR         = 1'b1;

    // Integer view of the sub-operation word
    typedef struct packed {
        logic       muldiv;
        logic       neg;                    // Subtract, or arithmetic right shift
        logic       inv;                    // Inverts eq, lts and ltu
        logic [2:0] sel;
    } int_ctl_t;

    // Multiply/divide view of the same word
    typedef struct packed {
        logic       muldiv;
        logic       sgn2;                   // Op2 is signed
        logic       sgn1;                   // Op1 is signed
        logic [2:0] sel;
    } md_ctl_t;

    typedef union packed {
        int_ctl_t int_ctl;
        md_ctl_t  md_ctl;
    } alu_sub_t;

    typedef struct packed {
        logic pc_next;                      // Result is the link address
        logic mem;                          // Carried on to the load stage
    } res_src_t;

    typedef struct packed {
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        alu_sub_t              alu_sub;
        logic [2:0]            funct3;
        logic [4:0]            rd;
        logic                  reg_write;
        logic                  store;
        logic                  jal_jalr;
        logic                  branch;
        logic [IADDR_BITS-1:0] pc;
        logic [IADDR_BITS-1:0] pc_next;
        logic [IADDR_BITS-1:0] pc_target;
        logic                  branch_pred;
        res_src_t              res_src;
        logic [XLEN-1:0]       reg_data2;
        logic                  csr_read;
        logic [XLEN-1:0]       csr_data;
        logic                  to_trap;
    } exec_req_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       add;
        logic [4:0]            rd;
        logic                  reg_write;
        logic                  store;
        logic [XLEN-1:0]       wdata;
        logic [3:0]            wsel;
        logic [2:0]            funct3;
        res_src_t              res_src;
        logic [IADDR_BITS-1:0] pc;
        logic                  to_trap;
    } exec_res_t;

    // Branch inputs handed from the ALU stage to the branch unit
    typedef struct packed {
        logic                  jal_jalr;
        logic                  branch;
        logic                  branch_pred;
        logic [IADDR_BITS-1:0] pc_target;
        logic [IADDR_BITS-1:0] pc_next;
        logic [2:0]            funct3;
    } branch_ctl_t;

    typedef struct packed {
        logic                  pc_select;
        logic [IADDR_BITS-1:0] target;
    } redirect_t;

endpackage

//--- tests/exec_properties.sv
`timescale 1ns/10ps

module exec_properties
(
    input wire i_clk,
    input wire i_reset,
    input wire i_flush,
    input wire i_req,
    input wire i_ack,
    input wire i_res_valid
);

    assert property (@(posedge i_clk) disable iff (i_reset)
                     $rose(i_ack) |-> $past(i_req))
    else $error("ack rose without a request");

    assert property (@(posedge i_clk) disable iff (i_reset)
                     i_ack && i_req |=> i_ack)
    else $error("ack dropped while the request was still high");

    // Result follows the capture edge by one cycle unless flushed
    assert property (@(posedge i_clk) disable iff (i_reset)
                     $rose(i_ack) && !i_flush |=> i_res_valid)
    else $error("valid missing one cycle after ack rose");

    assert property (@(posedge i_clk) disable iff (i_reset)
                     i_res_valid |-> $past(i_ack) && !$past(i_ack, 2))
    else $error("valid raised without a fresh ack");

    assert property (@(posedge i_clk) disable iff (i_reset)
                     i_res_valid |=> !i_res_valid)
    else $error("valid held for more than one cycle");

    assert property (@(posedge i_clk)
                     i_reset |=> !i_ack && !i_res_valid)
    else $error("ack or valid high after reset");

endmodule

bind exec_top exec_properties props0
(
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_flush     (i_flush),
    .i_req       (i_req),
    .i_ack       (o_ack),
    .i_res_valid (o_res_valid)
);

//--- tests/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

    localparam int TEST_CALLS  = 6;
    localparam int CYCLE_LIMIT = TEST_CALLS * 200 + 100;

    logic                                   i_clk;
    logic                                   i_reset;
    logic                                   i_flush;
    logic                                   i_req;
    rv_exec_pkg::exec_req_t                 i_issue;
    logic [rv_exec_pkg::IADDR_BITS-1:0]     i_fetch_pc;
    logic                                   o_ack;
    logic                                   o_res_valid;
    rv_exec_pkg::exec_res_t                 o_result;
    rv_exec_pkg::redirect_t                 o_redirect;

    integer                 seed = 32'h28fb_5cce;
    int                     errors;
    int                     checks;
    int                     issued;
    int                     writes;
    int                     valid_count;
    int                     write_count;
    int                     cycles;
    logic                   got_valid;
    rv_exec_pkg::exec_res_t got_res;
    rv_exec_pkg::redirect_t got_redir;

    exec_top dut0
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_flush     (i_flush),
        .i_req       (i_req),
        .i_issue     (i_issue),
        .i_fetch_pc  (i_fetch_pc),
        .o_ack       (o_ack),
        .o_res_valid (o_res_valid),
        .o_result    (o_result),
        .o_redirect  (o_redirect)
    );

    initial i_clk = 1'b0;

    always #20 i_clk = ~i_clk;

    // Counts every cycle that carries a result or a register write
    always @(negedge i_clk)
    begin
        if (!i_reset)
        begin
            if (o_res_valid)
            begin
                valid_count++;
            end
            if (o_result.reg_write)
            begin
                write_count++;
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("%s", what);
        end
    endtask

    function automatic rv_exec_pkg::exec_req_t plain_req();
        rv_exec_pkg::exec_req_t req;
        req           = '0;
        req.rd        = 5'd7;
        req.reg_write = 1'b1;
        return req;
    endfunction

    function automatic logic [31:0] int_ref(input logic [2:0] sel, input logic neg,
                                            input logic [31:0] a, input logic [31:0] b);
        case (sel)
            3'd0:    return neg ? (a - b) : (a + b);
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (neg)
                begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Wide signed arithmetic on sign or zero extended operands
    function automatic logic [31:0] md_ref(input logic [2:0] sel, input logic s1, input logic s2,
                                           input logic [31:0] a, input logic [31:0] b);
        logic signed [32:0] xa;
        logic signed [32:0] xb;
        logic signed [65:0] prod;
        logic signed [32:0] quot;
        logic signed [32:0] rem;
        xa   = s1 ? {a[31], a} : {1'b0, a};
        xb   = s2 ? {b[31], b} : {1'b0, b};
        prod = xa * xb;
        quot = xa / xb;
        rem  = xa % xb;
        case (sel)
            3'd0:             return prod[31:0];
            3'd1, 3'd2, 3'd3: return prod[63:32];
            3'd4, 3'd5:       return quot[31:0];
            default:          return rem[31:0];
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Issues one bundle by four-phase handshake and samples the result cycle
    task automatic issue_one(input rv_exec_pkg::exec_req_t req, input logic [31:0] fetch_pc,
                             input logic flush_it);
        @(posedge i_clk);
        i_req      <= 1'b1;
        i_issue    <= req;
        i_fetch_pc <= fetch_pc;
        @(posedge i_clk);
        i_flush <= flush_it;                    // Seen by the DUT on the edge after capture
        @(negedge i_clk);
        while (!o_ack)
        begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_req   <= 1'b0;
        i_flush <= 1'b0;
        @(negedge i_clk);
        got_valid = o_res_valid;
        got_res   = o_result;
        got_redir = o_redirect;
        if (flush_it)
        begin
            expect_true(!got_valid, "Flushed instruction still produced a valid pulse");
            expect_true(!got_redir.pc_select, "Flushed instruction still redirected fetch");
            compare_value("reg_write", got_res.reg_write, 32'h0);
            compare_value("store", got_res.store, 32'h0);
            compare_value("to_trap", got_res.to_trap, 32'h0);
        end
        else
        begin
            expect_true(got_valid, "No valid pulse in the cycle after ack rose");
            compare_value("reg_write", got_res.reg_write, req.reg_write);
            compare_value("store", got_res.store, req.store);
            compare_value("to_trap", got_res.to_trap, req.to_trap);
            compare_value("rd", got_res.rd, req.rd);
            compare_value("funct3", got_res.funct3, req.funct3);
            compare_value("res_src", got_res.res_src, req.res_src);
            compare_value("pc", got_res.pc, req.pc);
            issued++;
            if (req.reg_write)
            begin
                writes++;
            end
        end
        while (o_ack)
        begin
            @(negedge i_clk);
        end
        expect_true(!o_res_valid, "Valid pulse lasted longer than one cycle");
    endtask

    task automatic integer_ops();
        logic [2:0]             sels [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                             3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic                   negs [10] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1,
                                             1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        logic [31:0]            edges [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
        logic [31:0]            a;
        logic [31:0]            b;
        rv_exec_pkg::exec_req_t req;
        for (int op = 0; op < 10; op++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                a = (k < 3) ? edges[k] : $random(seed);
                b = (k < 3) ? edges[(k + 1) % 3] : $random(seed);
                req = plain_req();
                req.op1 = a;
                req.op2 = b;
                req.alu_sub.int_ctl.sel = sels[op];
                req.alu_sub.int_ctl.neg = negs[op];        // Compares run through the subtractor
                issue_one(req, 32'h0, 1'b0);
                compare_value("result", got_res.result, int_ref(sels[op], negs[op], a, b));
            end
        end
    endtask

    task automatic muldiv_ops();
        logic                   s1s [8] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        logic                   s2s [8] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        logic [31:0]            lhs [3] = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000};
        logic [31:0]            rhs [3] = '{32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
        logic [31:0]            a;
        logic [31:0]            b;
        rv_exec_pkg::exec_req_t req;
        for (int op = 0; op < 8; op++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                a = (k < 3) ? lhs[k] : $random(seed);
                b = (k < 3) ? rhs[k] : $random(seed);
                if (b == 32'h0)
                begin
                    b = 32'h1;
                end
                req = plain_req();
                req.op1 = a;
                req.op2 = b;
                req.alu_sub.md_ctl.sel    = op[2:0];
                req.alu_sub.md_ctl.sgn1   = s1s[op];
                req.alu_sub.md_ctl.sgn2   = s2s[op];
                req.alu_sub.md_ctl.muldiv = 1'b1;
                issue_one(req, 32'h0, 1'b0);
                compare_value("result", got_res.result, md_ref(op[2:0], s1s[op], s2s[op], a, b));
            end
        end
    endtask

    task automatic branch_decisions();
        logic [2:0]             f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [2:0]             f3;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            offset;
        logic [31:0]            fetch;
        int                     mode;
        logic                   taken;
        logic                   pred_ok;
        rv_exec_pkg::exec_req_t req;
        for (int i = 0; i < 7; i++)                        // Index 6 is a jump
        begin
            for (int k = 0; k < 3; k++)
            begin
                f3 = (i < 6) ? f3s[i] : 3'd0;
                a = (k == 0) ? $random(seed) : ((k == 1) ? 32'h8000_0000 : 32'h1);
                b = (k == 0) ? a : ((k == 1) ? 32'h1 : 32'h8000_0000);
                offset = $random(seed);
                mode = (i + k) % 3;                         // None, correct or wrong prediction
                req = plain_req();
                req.op1 = a;
                req.op2 = b;
                req.funct3 = f3;
                req.alu_sub.int_ctl.neg = 1'b1;
                req.alu_sub.int_ctl.inv = f3[0];
                req.pc = {$random(seed)} & 32'hffff_fffc;
                req.pc_next = req.pc + 32'h4;
                req.pc_target = req.pc + (offset & 32'h0000_0ffc) + 32'h8;
                req.branch_pred = (mode != 0);
                req.jal_jalr = (i == 6);
                req.branch = (i != 6);
                req.reg_write = (i == 6);
                req.res_src.pc_next = (i == 6);
                fetch = (mode == 1) ? req.pc_target : req.pc_next;
                issue_one(req, fetch, 1'b0);
                taken = (i == 6) || branch_taken(f3, a, b);
                pred_ok = (mode == 1);
                compare_value("pc_select", got_redir.pc_select, taken ^ pred_ok);
                compare_value("target", got_redir.target,
                              pred_ok ? req.pc_next : req.pc_target);
                if (i == 6)
                begin
                    compare_value("result", got_res.result, req.pc_next);
                end
            end
        end
    endtask

    task automatic store_lanes();
        logic [31:0]            data;
        logic [31:0]            exp_data;
        logic [3:0]             exp_sel;
        rv_exec_pkg::exec_req_t req;
        for (int f3 = 0; f3 < 3; f3++)
        begin
            for (int lo = 0; lo < 4; lo++)
            begin
                data = $random(seed);
                req = plain_req();
                req.reg_write = 1'b0;
                req.store = 1'b1;
                req.to_trap = lo[0];
                req.funct3 = f3[2:0];
                req.op1 = ({$random(seed)} & 32'hffff_fffc) | lo;
                req.op2 = {$random(seed)} & 32'hffff_fffc;
                req.reg_data2 = data;
                case (f3)
                    0:
                    begin
                        exp_data = {4{data[7:0]}};
                        exp_sel  = 4'b0000;
                        exp_sel[lo] = 1'b1;
                    end
                    1:
                    begin
                        exp_data = {2{data[15:0]}};
                        exp_sel  = (lo >= 2) ? 4'b1100 : 4'b0011;
                    end
                    default:
                    begin
                        exp_data = data;
                        exp_sel  = 4'b1111;
                    end
                endcase
                issue_one(req, 32'h0, 1'b0);
                compare_value("add", got_res.add, req.op1 + req.op2);
                compare_value("wdata", got_res.wdata, exp_data);
                compare_value("wsel", got_res.wsel, exp_sel);
            end
        end
    endtask

    task automatic result_priority();
        logic [31:0]            exp;
        rv_exec_pkg::exec_req_t req;
        for (int level = 0; level < 4; level++)
        begin
            req = plain_req();
            req.rd = level[4:0] + 5'd1;
            req.op1 = $random(seed);
            req.op2 = $random(seed);
            req.pc_next = $random(seed);
            req.csr_data = $random(seed);
            req.res_src.pc_next = (level == 0);
            req.res_src.mem = level[0];
            req.csr_read = (level <= 1);
            req.alu_sub.md_ctl.sgn1   = 1'b1;
            req.alu_sub.md_ctl.sgn2   = 1'b1;
            req.alu_sub.md_ctl.muldiv = (level <= 2);
            if (level == 3)
            begin
                req.alu_sub = '0;
                req.alu_sub.int_ctl.sel = 3'd4;
            end
            case (level)
                0:       exp = req.pc_next;
                1:       exp = req.csr_data;
                2:       exp = md_ref(3'd0, 1'b1, 1'b1, req.op1, req.op2);
                default: exp = req.op1 ^ req.op2;
            endcase
            issue_one(req, 32'h0, 1'b0);
            compare_value("result", got_res.result, exp);
        end
    endtask

    task automatic flush_and_count();
        rv_exec_pkg::exec_req_t req;
        req = plain_req();
        req.jal_jalr = 1'b1;
        req.res_src.pc_next = 1'b1;
        req.pc_next = 32'h0000_1004;
        req.pc_target = 32'h0000_2000;
        req.to_trap = 1'b1;
        issue_one(req, 32'h0000_1004, 1'b1);               // A taken jump that must not redirect
        req = plain_req();
        req.op1 = 32'h0000_0011;
        req.op2 = 32'h0000_0022;
        req.store = 1'b1;
        issue_one(req, 32'h0, 1'b1);
        issue_one(req, 32'h0, 1'b0);
        compare_value("result", got_res.result, 32'h0000_0033);
    endtask

    // Watchdog
    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles before the tests finished", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        i_reset    = 1'b1;
        i_flush    = 1'b0;
        i_req      = 1'b0;
        i_issue    = '0;
        i_fetch_pc = '0;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;
        integer_ops();
        muldiv_ops();
        branch_decisions();
        store_lanes();
        result_priority();
        flush_and_count();
        @(negedge i_clk);
        compare_value("valid_count", valid_count, issued);
        compare_value("write_count", write_count, writes);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/rv_exec_pkg.sv
logic/exec_issue.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_store_fmt.sv
logic/exec_top.sv
tests/exec_properties.sv
tests/exec_tb.sv
